/* rtl/monoMatrixPkg.sv */
`default_nettype none

package monoMatrixPkg;

    // Front-end flavors, one hit-OR and one timestamp bus each
    localparam int NumFlavors = 4;

    // Columns reachable by the injection pulse
    localparam int NumCols = 16;

    // Digital monitor pixels per flavor
    localparam int DigMonWidth = 8;

    // Bunch-crossing time base
    localparam int BcidWidth = 6;  // Wraps every 64 crossings

    // Gray-coded timestamp as it travels to the columns
    typedef logic [BcidWidth-1:0] bcidT;

endpackage

`default_nettype wire

/* rtl/monoConfPkg.sv */
`default_nettype none

package monoConfPkg;

    // Switch lines of one DAC selector
    localparam int DacLines = 32;

    // Default DAC line choices
    localparam int VhDefaultLine = 20;    // One-hot VH line
    localparam int IbiasOnLines = 12;     // Thermometer width, centered
    localparam int IbiasLowLine = (DacLines - IbiasOnLines) / 2;

    // Decoded view, first field is the MSB end of the chain
    typedef struct packed {
        logic [monoMatrixPkg::NumFlavors-1:0] EnFlavor;
        logic [monoMatrixPkg::NumFlavors-1:0] EnHitorOut;
        logic [monoMatrixPkg::NumCols-1:0]    ColPulseSel;
        logic                                 InjMonL;
        logic                                 InjMonR;
        logic                                 IresetBit;   // High leakage range when set
        logic [DacLines-1:0]                  VhSel;       // One-hot
        logic [DacLines-1:0]                  IbiasSel;    // Thermometer
    } confFieldsT;

    localparam int ConfBits = $bits(confFieldsT);

    // Same word as the serial chain sees it and as the matrix uses it
    typedef union packed {
        logic [ConfBits-1:0] Flat;
        confFieldsT          Fields;
    } confWordT;

    // Power-up values, matrix controls all off
    localparam confFieldsT DefaultFields = '{
        EnFlavor:    '0,
        EnHitorOut:  '0,
        ColPulseSel: '0,
        InjMonL:     1'b0,
        InjMonR:     1'b0,
        IresetBit:   1'b1,
        VhSel:       DacLines'(1) << VhDefaultLine,
        IbiasSel:    ((DacLines'(1) << IbiasOnLines) - DacLines'(1)) << IbiasLowLine
    };

    // Lines 10 to 21 for IBIAS, line 20 for VH
    localparam confWordT ConfDefault = confWordT'(DefaultFields);

endpackage

`default_nettype wire

/* rtl/matrixCtrlIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface matrixCtrlIf;

    logic [monoMatrixPkg::NumFlavors-1:0] EnFlavor;     // Timestamp bus enable
    logic [monoMatrixPkg::NumFlavors-1:0] EnHitorOut;   // Hit-OR output enable
    logic [monoMatrixPkg::NumCols-1:0]    ColPulseSel;  // Injected columns
    logic                                 InjMonL;
    logic                                 InjMonR;

    // Configuration side
    modport src (
        output EnFlavor, EnHitorOut, ColPulseSel, InjMonL, InjMonR
    );

    // Matrix side
    modport dst (
        input EnFlavor, EnHitorOut, ColPulseSel, InjMonL, InjMonR
    );

endinterface

`default_nettype wire

/* rtl/globalConfReg.sv */
`timescale 1ns/10ps
`default_nettype none

module globalConfReg (
    input  logic                              ClkBx,
    input  logic                              reset_ff,
    input  logic                              ShiftEn,
    input  logic                              Load,
    input  logic                              Si,
    input  logic                              DefConf,
    output logic                              So,
    matrixCtrlIf.src                          Ctrl,
    output logic [monoConfPkg::DacLines-1:0]  VhSel,
    output logic [monoConfPkg::DacLines-1:0]  IbiasSel,
    output logic                              IresetBit
);

    import monoConfPkg::*;

    logic [ConfBits-1:0] ShiftChain;
    confWordT            Shadow;
    confWordT            ActiveConf;

    // Serial chain, Si enters at bit 0 and walks toward the MSB
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            ShiftChain <= '0;
        end else if (ShiftEn) begin
            ShiftChain <= {ShiftChain[ConfBits-2:0], Si};
        end
    end

    // Shadow holds the configuration the matrix actually sees
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            Shadow <= '0;
        end else if (Load) begin
            Shadow.Flat <= ShiftChain;
        end
    end

    // Chain MSB is a flop already, so readback moves with each shift
    assign So = ShiftChain[ConfBits-1];

    // Default word wins for as long as DefConf is held
    assign ActiveConf = DefConf ? ConfDefault : Shadow;

    // Field decode toward the matrix
    always_comb begin
        Ctrl.EnFlavor    = ActiveConf.Fields.EnFlavor;
        Ctrl.EnHitorOut  = ActiveConf.Fields.EnHitorOut;
        Ctrl.ColPulseSel = ActiveConf.Fields.ColPulseSel;
        Ctrl.InjMonL     = ActiveConf.Fields.InjMonL;
        Ctrl.InjMonR     = ActiveConf.Fields.InjMonR;
    end

    // DAC selectors leave the core directly
    always_comb begin
        VhSel     = ActiveConf.Fields.VhSel;
        IbiasSel  = ActiveConf.Fields.IbiasSel;
        IresetBit = ActiveConf.Fields.IresetBit;
    end

    // A load during a shift would capture a half-moved word
    ShiftLoadExclusive: assert property (
        @(posedge ClkBx) disable iff (reset_ff)
        !(ShiftEn && Load)
    ) else $error("ShiftEn and Load high in the same cycle");

endmodule

`default_nettype wire

/* rtl/bcidCounter.sv */
`timescale 1ns/10ps
`default_nettype none

module bcidCounter (
    input  logic               ClkBx,
    input  logic               reset_ff,
    input  logic               ResetBcid,
    output monoMatrixPkg::bcidT Bcid
);

    import monoMatrixPkg::*;

    logic ResetReq;   // ResetBcid one crossing later
    bcidT BinCount;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            ResetReq <= 1'b0;
            BinCount <= '0;
        end else begin
            ResetReq <= ResetBcid;
            if (ResetReq) begin
                BinCount <= '0;
            end else begin
                BinCount <= BinCount + 1'b1;   // Natural wrap at 64
            end
        end
    end

    // Gray code so the columns never latch a multi-bit transition
    assign Bcid = (BinCount >> 1) ^ BinCount;

    // Only a BCID reset may break the one-bit step
    GrayStep: assert property (
        @(posedge ClkBx) disable iff (reset_ff)
        (!$past(reset_ff) && !$past(ResetReq)) |-> $onehot(Bcid ^ $past(Bcid))
    ) else $error("Bcid changed in more than one bit");

endmodule

`default_nettype wire

/* rtl/matrixDrive.sv */
`timescale 1ns/10ps
`default_nettype none

module matrixDrive (
    input  logic                                  ClkBx,
    input  logic                                  reset_ff,
    matrixCtrlIf.dst                              Ctrl,
    input  monoMatrixPkg::bcidT                   Bcid,
    input  logic                                  Pulse,
    input  logic [monoMatrixPkg::NumFlavors-1:0]
                 [monoMatrixPkg::DigMonWidth-1:0] DigMon,
    output logic [monoMatrixPkg::NumCols-1:0]     InjIn,
    output logic                                  InjMonLOut,
    output logic                                  InjMonROut,
    output logic [monoMatrixPkg::NumFlavors-1:0]  HitOr,
    output monoMatrixPkg::bcidT [monoMatrixPkg::NumFlavors-1:0] BcidCol
);

    import monoMatrixPkg::*;

    // Test pulse reaches only the selected columns
    assign InjIn      = {NumCols{Pulse}} & Ctrl.ColPulseSel;
    assign InjMonLOut = Pulse & Ctrl.InjMonL;   // Left monitor pixel
    assign InjMonROut = Pulse & Ctrl.InjMonR;   // Right monitor pixel

    // Fast OR of the monitor pixels per flavor
    always_comb begin
        for (int f = 0; f < NumFlavors; f++) begin
            HitOr[f] = (|DigMon[f]) & Ctrl.EnHitorOut[f];
        end
    end

    // Timestamp buses, a disabled flavor sees a quiet bus
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            BcidCol <= '0;
        end else begin
            for (int f = 0; f < NumFlavors; f++) begin
                if (Ctrl.EnFlavor[f]) begin
                    BcidCol[f] <= Bcid;
                end else begin
                    BcidCol[f] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/monopixCore.sv */
`timescale 1ns/10ps
`default_nettype none

module monopixCore (
    input  logic                                  ClkBx,
    input  logic                                  reset_ff,
    input  logic                                  ShiftEn,
    input  logic                                  Load,
    input  logic                                  Si,
    input  logic                                  DefConf,
    input  logic                                  ResetBcid,
    input  logic                                  Pulse,
    input  logic [monoMatrixPkg::NumFlavors-1:0]
                 [monoMatrixPkg::DigMonWidth-1:0] DigMon,
    output logic                                  So,
    output logic [monoMatrixPkg::NumCols-1:0]     InjIn,
    output logic                                  InjMonLOut,
    output logic                                  InjMonROut,
    output logic [monoMatrixPkg::NumFlavors-1:0]  HitOr,
    output monoMatrixPkg::bcidT [monoMatrixPkg::NumFlavors-1:0] BcidCol,
    output logic [monoConfPkg::DacLines-1:0]      VhSel,
    output logic [monoConfPkg::DacLines-1:0]      IbiasSel,
    output logic                                  IresetBit
);

    import monoMatrixPkg::*;

    bcidT BcidGray;   // Shared time base for all flavors

    matrixCtrlIf i_ctrlIf ();

    // Configuration and time base run side by side
    globalConfReg i_globalConfReg (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ShiftEn   (ShiftEn),
        .Load      (Load),
        .Si        (Si),
        .DefConf   (DefConf),
        .So        (So),
        .Ctrl      (i_ctrlIf.src),
        .VhSel     (VhSel),
        .IbiasSel  (IbiasSel),
        .IresetBit (IresetBit)
    );

    bcidCounter i_bcidCounter (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ResetBcid (ResetBcid),
        .Bcid      (BcidGray)
    );

    matrixDrive i_matrixDrive (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .Ctrl       (i_ctrlIf.dst),
        .Bcid       (BcidGray),
        .Pulse      (Pulse),
        .DigMon     (DigMon),
        .InjIn      (InjIn),
        .InjMonLOut (InjMonLOut),
        .InjMonROut (InjMonROut),
        .HitOr      (HitOr),
        .BcidCol    (BcidCol)
    );

endmodule

`default_nettype wire

/* tests/tb_monopixCore.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_monopixCore;

    import monoMatrixPkg::*;
    import monoConfPkg::*;

    localparam int NumRows = 8;
    localparam int WatchdogCycles = NumRows * (ConfBits + 20) + 500;
    localparam int VhLine = 20;        // Default VH line
    localparam int IbiasFirst = 10;    // Default IBIAS thermometer span
    localparam int IbiasLast = 21;
    localparam int TsCycles = 70;      // Runs past one BCID wrap

    // One row of stimulus with its expected responses
    typedef struct packed {
        confWordT                               Conf;
        logic                                   DefConf;
        logic                                   Pulse;
        logic [NumFlavors-1:0][DigMonWidth-1:0] DigMon;
        logic [NumCols-1:0]                     ExpInjIn;
        logic                                   ExpMonL;
        logic                                   ExpMonR;
        logic [NumFlavors-1:0]                  ExpHitOr;
        logic [DacLines-1:0]                    ExpVh;
        logic [DacLines-1:0]                    ExpIbias;
        logic                                   ExpIreset;
    } testRowT;

    logic                                   ClkBx;
    logic                                   reset_ff;
    logic                                   ShiftEn;
    logic                                   Load;
    logic                                   Si;
    logic                                   DefConf;
    logic                                   ResetBcid;
    logic                                   Pulse;
    logic [NumFlavors-1:0][DigMonWidth-1:0] DigMon;
    logic                                   So;
    logic [NumCols-1:0]                     InjIn;
    logic                                   InjMonLOut;
    logic                                   InjMonROut;
    logic [NumFlavors-1:0]                  HitOr;
    bcidT [NumFlavors-1:0]                  BcidCol;
    logic [DacLines-1:0]                    VhSel;
    logic [DacLines-1:0]                    IbiasSel;
    logic                                   IresetBit;

    testRowT     TestRows [NumRows];
    string       RowName [NumRows];
    confFieldsT  DefFields;   // Default word rebuilt from its field rules
    int          PassCount;
    int          FailCount;
    int          ErrCount;

    monopixCore i_dut (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .ShiftEn    (ShiftEn),
        .Load       (Load),
        .Si         (Si),
        .DefConf    (DefConf),
        .ResetBcid  (ResetBcid),
        .Pulse      (Pulse),
        .DigMon     (DigMon),
        .So         (So),
        .InjIn      (InjIn),
        .InjMonLOut (InjMonLOut),
        .InjMonROut (InjMonROut),
        .HitOr      (HitOr),
        .BcidCol    (BcidCol),
        .VhSel      (VhSel),
        .IbiasSel   (IbiasSel),
        .IresetBit  (IresetBit)
    );

    initial ClkBx = 1'b0;
    always #2 ClkBx = ~ClkBx;

    function automatic bcidT grayOf(input int count);
        bcidT bin;
        bin = bcidT'(count);
        return bin ^ (bin >> 1);
    endfunction

    task automatic reportMismatch(input string testName, input string what,
                                  input string expStr, input string actStr);
        $display("** Error: %s %s expected %s actual %s", testName, what, expStr, actStr);
        ErrCount++;
    endtask

    task automatic finishTest(input string testName);
        if (ErrCount == 0) begin
            $display("PASS  %s", testName);
            PassCount++;
        end else begin
            $display("FAIL  %s (%0d errors)", testName, ErrCount);
            FailCount++;
        end
    endtask

    task automatic buildDefaults;
        DefFields = '0;
        DefFields.IresetBit = 1'b1;
        DefFields.VhSel[VhLine] = 1'b1;
        for (int l = IbiasFirst; l <= IbiasLast; l++) begin
            DefFields.IbiasSel[l] = 1'b1;
        end
    endtask

    task automatic buildTable;
        testRowT    row;
        logic [95:0] wide;
        confFieldsT eff;
        for (int i = 0; i < NumRows; i++) begin
            row = '0;
            wide = {$urandom(), $urandom(), $urandom()};
            row.Conf.Flat = wide[ConfBits-1:0];
            row.Pulse = ($urandom() & 1) != 0;
            for (int f = 0; f < NumFlavors; f++) begin   // Some flavors stay quiet
                row.DigMon[f] = ($urandom() % 3 == 0) ? '0 : DigMonWidth'($urandom());
            end
            RowName[i] = $sformatf("random%0d", i);
            case (i)
                0: begin
                    row.Conf = '0;
                    row.Pulse = 1'b1;
                    row.DigMon = '1;
                    RowName[i] = "allZero";
                end
                1: begin
                    row.DefConf = 1'b1;   // Random word loaded but overridden
                    row.Pulse = 1'b1;
                    row.DigMon = '1;
                    RowName[i] = "defaultWord";
                end
                2: begin
                    row.Conf.Flat = '1;
                    row.Pulse = 1'b1;
                    RowName[i] = "allOnes";
                end
                3: begin
                    row.Pulse = 1'b0;
                    RowName[i] = "pulseLow";
                end
                default: ;
            endcase
            eff = row.DefConf ? DefFields : row.Conf.Fields;
            for (int c = 0; c < NumCols; c++) begin
                row.ExpInjIn[c] = row.Pulse & eff.ColPulseSel[c];
            end
            row.ExpMonL = row.Pulse & eff.InjMonL;
            row.ExpMonR = row.Pulse & eff.InjMonR;
            for (int f = 0; f < NumFlavors; f++) begin
                row.ExpHitOr[f] = eff.EnHitorOut[f] & (row.DigMon[f] != '0);
            end
            row.ExpVh = eff.VhSel;
            row.ExpIbias = eff.IbiasSel;
            row.ExpIreset = eff.IresetBit;
            TestRows[i] = row;
        end
    endtask

    // Shift a new word in MSB first while the old chain content appears on So
    task automatic shiftWord(input confWordT word, input confWordT chainWord,
                             input string testName);
        for (int i = 0; i < ConfBits; i++) begin
            @(posedge ClkBx);
            ShiftEn <= 1'b1;
            Si      <= word.Flat[ConfBits-1-i];
            @(negedge ClkBx);
            if (So !== chainWord.Flat[ConfBits-1-i]) begin
                reportMismatch(testName, $sformatf("So bit %0d", ConfBits - 1 - i),
                               $sformatf("%b", chainWord.Flat[ConfBits-1-i]),
                               $sformatf("%b", So));
            end
        end
    endtask

    task automatic loadWord(input logic defLevel);
        @(posedge ClkBx);
        ShiftEn <= 1'b0;
        Load    <= 1'b1;
        DefConf <= defLevel;
    endtask

    task automatic checkResetState;
        ErrCount = 0;
        if (So !== 1'b0) reportMismatch("resetState", "So", "0", $sformatf("%b", So));
        if (InjIn !== '0) reportMismatch("resetState", "InjIn", "0", $sformatf("%h", InjIn));
        if (InjMonLOut !== 1'b0 || InjMonROut !== 1'b0) begin
            reportMismatch("resetState", "InjMon", "00",
                           $sformatf("%b%b", InjMonLOut, InjMonROut));
        end
        if (HitOr !== '0) reportMismatch("resetState", "HitOr", "0", $sformatf("%h", HitOr));
        if (BcidCol !== '0) begin
            reportMismatch("resetState", "BcidCol", "0", $sformatf("%h", BcidCol));
        end
        if (VhSel !== '0 || IbiasSel !== '0 || IresetBit !== 1'b0) begin
            reportMismatch("resetState", "DAC", "0",
                           $sformatf("%h %h %b", VhSel, IbiasSel, IresetBit));
        end
        finishTest("resetState");
    endtask

    task automatic runRow(input int idx, input confWordT chainWord);
        testRowT row;
        string   name;
        row  = TestRows[idx];
        name = RowName[idx];
        ErrCount = 0;
        shiftWord(row.Conf, chainWord, name);
        loadWord(row.DefConf);
        Pulse  <= row.Pulse;
        DigMon <= row.DigMon;
        @(posedge ClkBx);
        Load <= 1'b0;
        @(negedge ClkBx);   // Loaded word visible after the Load edge
        if (InjIn !== row.ExpInjIn) begin
            reportMismatch(name, "InjIn", $sformatf("%h", row.ExpInjIn), $sformatf("%h", InjIn));
        end
        if (InjMonLOut !== row.ExpMonL) begin
            reportMismatch(name, "InjMonLOut", $sformatf("%b", row.ExpMonL),
                           $sformatf("%b", InjMonLOut));
        end
        if (InjMonROut !== row.ExpMonR) begin
            reportMismatch(name, "InjMonROut", $sformatf("%b", row.ExpMonR),
                           $sformatf("%b", InjMonROut));
        end
        if (HitOr !== row.ExpHitOr) begin
            reportMismatch(name, "HitOr", $sformatf("%h", row.ExpHitOr), $sformatf("%h", HitOr));
        end
        if (VhSel !== row.ExpVh) begin
            reportMismatch(name, "VhSel", $sformatf("%h", row.ExpVh), $sformatf("%h", VhSel));
        end
        if (IbiasSel !== row.ExpIbias) begin
            reportMismatch(name, "IbiasSel", $sformatf("%h", row.ExpIbias),
                           $sformatf("%h", IbiasSel));
        end
        if (IresetBit !== row.ExpIreset) begin
            reportMismatch(name, "IresetBit", $sformatf("%b", row.ExpIreset),
                           $sformatf("%b", IresetBit));
        end
        finishTest(name);
    endtask

    task automatic checkTimestamp(input confWordT chainWord);
        confWordT word;
        bcidT     expBus;
        ErrCount = 0;
        word = '0;
        word.Fields.EnFlavor = 4'b0101;   // Flavors 1 and 3 stay disabled
        shiftWord(word, chainWord, "timestamp");
        loadWord(1'b0);
        @(posedge ClkBx);
        Load      <= 1'b0;
        ResetBcid <= 1'b1;
        @(posedge ClkBx);   // Edge n samples the BCID reset
        ResetBcid <= 1'b0;
        @(posedge ClkBx);   // Count is zero after n+1
        @(posedge ClkBx);   // Bus holds Gray 0 after n+2
        for (int k = 0; k < TsCycles; k++) begin
            @(negedge ClkBx);
            for (int f = 0; f < NumFlavors; f++) begin
                expBus = word.Fields.EnFlavor[f] ? grayOf(k % 64) : '0;
                if (BcidCol[f] !== expBus) begin
                    reportMismatch("timestamp", $sformatf("BcidCol[%0d] step %0d", f, k),
                                   $sformatf("%h", expBus), $sformatf("%h", BcidCol[f]));
                end
            end
        end
        finishTest("timestamp");
    endtask

    initial begin
        repeat (WatchdogCycles) @(posedge ClkBx);
        $display("Timeout: the run did not finish within %0d clock cycles", WatchdogCycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'hd1e4_72e2));
        PassCount = 0;
        FailCount = 0;
        reset_ff  <= 1'b1;
        ShiftEn   <= 1'b0;
        Load      <= 1'b0;
        Si        <= 1'b0;
        DefConf   <= 1'b0;
        ResetBcid <= 1'b0;
        Pulse     <= 1'b0;
        DigMon    <= '0;
        buildDefaults();
        buildTable();
        repeat (8) @(posedge ClkBx);
        reset_ff <= 1'b0;
        Pulse    <= 1'b1;   // Active stimulus must not leak through a cleared config
        DigMon   <= '1;
        @(negedge ClkBx);
        checkResetState();
        for (int i = 0; i < NumRows; i++) begin
            runRow(i, (i == 0) ? confWordT'('0) : TestRows[i-1].Conf);
        end
        checkTimestamp(TestRows[NumRows-1].Conf);
        $display("Tests passed: %0d, failed: %0d", PassCount, FailCount);
        if (FailCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
rtl/monoMatrixPkg.sv
rtl/monoConfPkg.sv
rtl/matrixCtrlIf.sv
rtl/globalConfReg.sv
rtl/bcidCounter.sv
rtl/matrixDrive.sv
rtl/monopixCore.sv
tests/tb_monopixCore.sv

/* Makefile */
TOP := tb_monopixCore

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
